/* exec_config.svh */
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// Register index width, 32 architectural registers
`define REGISTER_WIDTH 5

`define DATA_WIDTH 32

// Program counter width
`define ADDR_WIDTH 32

`define NUM_REGS (1 << `REGISTER_WIDTH)

`endif

/* exec_pkg.sv */
`include "exec_config.svh"

package exec_pkg;

  // Decoded operation, OP_MUL goes to the multiply pipeline and the rest to the ALU
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_OR  = 3'd3,
    OP_XOR = 3'd4,
    OP_LI  = 3'd5,
    OP_MUL = 3'd6
  } opcode_t;

  typedef logic [15:0] imm_t; // Zero-extended by OP_LI

  // 34-bit decoded instruction as it arrives from decode
  typedef struct packed {
    opcode_t                    op;
    logic [`REGISTER_WIDTH-1:0] rd;
    logic [`REGISTER_WIDTH-1:0] rs1;
    logic [`REGISTER_WIDTH-1:0] rs2;
    imm_t                       imm;
  } instruction_t;

endpackage : exec_pkg

/* exec_wb_if.sv */
`timescale 1ns/1ps
`include "exec_config.svh"

// One writeback source into the register file
interface exec_wb_if;
  import exec_pkg::*;

  logic                       valid;  // One-cycle strobe per result
  logic [`REGISTER_WIDTH-1:0] wr_reg;
  logic [`DATA_WIDTH-1:0]     result;
  logic [`ADDR_WIDTH-1:0]     debug_pc;
  instruction_t               debug_instr;

  modport src (
    output valid,
    output wr_reg,
    output result,
    output debug_pc,
    output debug_instr
  );

  modport dst (
    input valid,
    input wr_reg,
    input result,
    input debug_pc,
    input debug_instr
  );

endinterface : exec_wb_if

/* issue_ctrl.sv */
`timescale 1ns/1ps
`include "exec_config.svh"

module issue_ctrl (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       instr_valid_i,
  input  var exec_pkg::instruction_t instr_i,
  input  logic [`ADDR_WIDTH-1:0]     pc_i,
  input  logic [`DATA_WIDTH-1:0]     rs1_data_i,
  input  logic [`DATA_WIDTH-1:0]     rs2_data_i,
  input  logic                       wb_is_next_cycle_i,
  input  logic                       mul_done_i,
  input  logic [`REGISTER_WIDTH-1:0] mul_done_reg_i,
  output logic                       instr_stall_o,
  output logic [`REGISTER_WIDTH-1:0] rs1_addr_o,
  output logic [`REGISTER_WIDTH-1:0] rs2_addr_o,
  output logic                       alu_start_o,
  output logic                       mul_start_o,
  output exec_pkg::opcode_t          op_o,
  output logic [`REGISTER_WIDTH-1:0] rd_o,
  output logic [`DATA_WIDTH-1:0]     a_o,
  output logic [`DATA_WIDTH-1:0]     b_o,
  output exec_pkg::imm_t             imm_o,
  output logic [`ADDR_WIDTH-1:0]     pc_o,
  output exec_pkg::instruction_t     instr_o
);
  import exec_pkg::*;

  logic [`NUM_REGS-1:0] pending_q; // Destinations of multiplies still in flight
  logic [`NUM_REGS-1:0] set_mask;
  logic [`NUM_REGS-1:0] clr_mask;
  logic                 is_mul;
  logic                 hazard;
  logic                 accept;

  // Operands are read straight from the presented instruction
  assign rs1_addr_o = instr_i.rs1;
  assign rs2_addr_o = instr_i.rs2;

  assign is_mul = (instr_i.op == OP_MUL);

  // The rd check also keeps two multiplies to one register from overlapping
  assign hazard = pending_q[instr_i.rs1] | pending_q[instr_i.rs2] | pending_q[instr_i.rd];

  // An ALU result would land on top of a multiply writeback
  assign instr_stall_o = instr_valid_i & (hazard | (~is_mul & wb_is_next_cycle_i));

  assign accept      = instr_valid_i & ~instr_stall_o;
  assign alu_start_o = accept & ~is_mul;
  assign mul_start_o = accept & is_mul;

  assign op_o    = instr_i.op;
  assign rd_o    = instr_i.rd;
  assign a_o     = rs1_data_i;
  assign b_o     = rs2_data_i;
  assign imm_o   = instr_i.imm;
  assign pc_o    = pc_i;
  assign instr_o = instr_i;

  always_comb begin
    set_mask = '0;
    clr_mask = '0;
    if (mul_start_o) begin
      set_mask[instr_i.rd] = 1'b1;
    end
    if (mul_done_i) begin
      clr_mask[mul_done_reg_i] = 1'b1;
    end
  end

  // A set and a clear never hit the same bit, since rd is still pending at writeback
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      pending_q <= '0;
    end else begin
      pending_q <= (pending_q & ~clr_mask) | set_mask;
    end
  end

  // The ALU and the multiplier never write back in the same cycle
  a_no_alu_on_mul_wb : assert property (
    @(posedge clk_i) disable iff (!rst_i)
    !(alu_start_o && wb_is_next_cycle_i)
  );

  // Every multiply writeback matches a destination that was marked pending at issue
  a_done_was_pending : assert property (
    @(posedge clk_i) disable iff (!rst_i)
    mul_done_i |-> pending_q[mul_done_reg_i]
  );

endmodule : issue_ctrl

/* alu_stage.sv */
`timescale 1ns/1ps
`include "exec_config.svh"

module alu_stage (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       start_i,
  input  exec_pkg::opcode_t          op_i,
  input  logic [`REGISTER_WIDTH-1:0] rd_i,
  input  logic [`DATA_WIDTH-1:0]     a_i,
  input  logic [`DATA_WIDTH-1:0]     b_i,
  input  exec_pkg::imm_t             imm_i,
  input  logic [`ADDR_WIDTH-1:0]     debug_pc_i,
  input  var exec_pkg::instruction_t debug_instr_i,
  exec_wb_if.src                     wb
);
  import exec_pkg::*;

  logic [`DATA_WIDTH-1:0]     result_d;
  logic                       valid_q;
  logic [`REGISTER_WIDTH-1:0] wr_reg_q;
  logic [`DATA_WIDTH-1:0]     result_q;
  logic [`ADDR_WIDTH-1:0]     pc_q;
  instruction_t               instr_q;

  always_comb begin
    case (op_i)
      OP_ADD:  result_d = a_i + b_i;
      OP_SUB:  result_d = a_i - b_i;
      OP_AND:  result_d = a_i & b_i;
      OP_OR:   result_d = a_i | b_i;
      OP_XOR:  result_d = a_i ^ b_i;
      OP_LI:   result_d = `DATA_WIDTH'(imm_i);
      default: result_d = '0; // OP_MUL never reaches this unit
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= start_i; // One result per start, so the strobe lasts one cycle
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      wr_reg_q <= rd_i;
      result_q <= result_d;
      pc_q     <= debug_pc_i;
      instr_q  <= debug_instr_i;
    end
  end

  assign wb.valid       = valid_q;
  assign wb.wr_reg      = wr_reg_q;
  assign wb.result      = result_q;
  assign wb.debug_pc    = pc_q;
  assign wb.debug_instr = instr_q;

  // Issue must route multiplies to the pipeline
  a_no_mul_in_alu : assert property (
    @(posedge clk_i) disable iff (!rst_i)
    start_i |-> (op_i != OP_MUL)
  );

endmodule : alu_stage

/* ex_stages.sv */
`timescale 1ns/1ps
`include "exec_config.svh"

module ex_stages (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       valid_i,
  input  logic [`REGISTER_WIDTH-1:0] wr_reg_i,
  input  logic [`DATA_WIDTH-1:0]     a_i,
  input  logic [`DATA_WIDTH-1:0]     b_i,
  input  logic [`ADDR_WIDTH-1:0]     debug_pc_i,
  input  var exec_pkg::instruction_t debug_instr_i,
  output logic                       wb_is_next_cycle_o,
  exec_wb_if.src                     wb
);
  import exec_pkg::*;

  localparam int STAGES = 5;

  // Index 0 is the first stage, STAGES-1 drives writeback
  logic [STAGES-1:0]          valid_q;
  logic [`REGISTER_WIDTH-1:0] wr_reg_q [STAGES];
  logic [`DATA_WIDTH-1:0]     result_q [STAGES];
  logic [`ADDR_WIDTH-1:0]     pc_q     [STAGES];
  instruction_t               instr_q  [STAGES];

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[STAGES-2:0], valid_i};
    end
  end

  // Payload shifts every cycle, only the valid bits matter
  always_ff @(posedge clk_i) begin
    wr_reg_q[0] <= wr_reg_i;
    result_q[0] <= a_i * b_i; // Lower DATA_WIDTH bits of the product
    pc_q[0]     <= debug_pc_i;
    instr_q[0]  <= debug_instr_i;
    for (int i = 1; i < STAGES; i++) begin
      wr_reg_q[i] <= wr_reg_q[i-1];
      result_q[i] <= result_q[i-1];
      pc_q[i]     <= pc_q[i-1];
      instr_q[i]  <= instr_q[i-1];
    end
  end

  // Issue logic uses this to hold back ALU instructions for one cycle
  assign wb_is_next_cycle_o = valid_q[STAGES-2];

  assign wb.valid       = valid_q[STAGES-1];
  assign wb.wr_reg      = wr_reg_q[STAGES-1];
  assign wb.result      = result_q[STAGES-1];
  assign wb.debug_pc    = pc_q[STAGES-1];
  assign wb.debug_instr = instr_q[STAGES-1];

  // Fixed latency, nothing inside the pipeline ever stalls
  a_fixed_latency : assert property (
    @(posedge clk_i) disable iff (!rst_i)
    wb.valid |-> $past(valid_i, STAGES)
  );

endmodule : ex_stages

/* regfile_wb.sv */
`timescale 1ns/1ps
`include "exec_config.svh"

module regfile_wb (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic [`REGISTER_WIDTH-1:0] rs1_addr_i,
  input  logic [`REGISTER_WIDTH-1:0] rs2_addr_i,
  input  logic [`REGISTER_WIDTH-1:0] dbg_raddr_i,
  exec_wb_if.dst                     alu_wb,
  exec_wb_if.dst                     mul_wb,
  output logic [`DATA_WIDTH-1:0]     rs1_data_o,
  output logic [`DATA_WIDTH-1:0]     rs2_data_o,
  output logic [`DATA_WIDTH-1:0]     dbg_rdata_o,
  output logic                       retire_valid_o,
  output logic [`REGISTER_WIDTH-1:0] retire_reg_o,
  output logic [`DATA_WIDTH-1:0]     retire_data_o,
  output logic [`ADDR_WIDTH-1:0]     retire_pc_o,
  output logic                       mul_done_o,
  output logic [`REGISTER_WIDTH-1:0] mul_done_reg_o
);

  logic [`DATA_WIDTH-1:0] regs_q [`NUM_REGS];

  // Sources are exclusive, so a plain select is enough
  assign retire_valid_o = alu_wb.valid | mul_wb.valid;
  assign retire_reg_o   = mul_wb.valid ? mul_wb.wr_reg      : alu_wb.wr_reg;
  assign retire_data_o  = mul_wb.valid ? mul_wb.result      : alu_wb.result;
  assign retire_pc_o    = mul_wb.valid ? mul_wb.debug_pc    : alu_wb.debug_pc;

  assign mul_done_o     = mul_wb.valid;
  assign mul_done_reg_o = mul_wb.wr_reg;

  function automatic logic [`DATA_WIDTH-1:0] read_port(
    input logic [`REGISTER_WIDTH-1:0] addr
  );
    if (retire_valid_o && (retire_reg_o == addr)) begin
      return retire_data_o; // Value written at the coming edge
    end
    return regs_q[addr];
  endfunction

  always_comb begin
    rs1_data_o  = read_port(rs1_addr_i);
    rs2_data_o  = read_port(rs2_addr_i);
    dbg_rdata_o = read_port(dbg_raddr_i);
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (retire_valid_o) begin
      regs_q[retire_reg_o] <= retire_data_o;
    end
  end

  a_one_writer : assert property (
    @(posedge clk_i) disable iff (!rst_i)
    !(alu_wb.valid && mul_wb.valid)
  );

endmodule : regfile_wb

/* exec_top.sv */
`timescale 1ns/1ps
`include "exec_config.svh"

module exec_top (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       instr_valid_i,
  input  var exec_pkg::instruction_t instr_i,
  input  logic [`ADDR_WIDTH-1:0]     pc_i,
  input  logic [`REGISTER_WIDTH-1:0] dbg_raddr_i,
  output logic                       instr_stall_o,
  output logic                       retire_valid_o,
  output logic [`REGISTER_WIDTH-1:0] retire_reg_o,
  output logic [`DATA_WIDTH-1:0]     retire_data_o,
  output logic [`ADDR_WIDTH-1:0]     retire_pc_o,
  output logic [`DATA_WIDTH-1:0]     dbg_rdata_o
);
  import exec_pkg::*;

  logic [`REGISTER_WIDTH-1:0] rs1_addr;
  logic [`REGISTER_WIDTH-1:0] rs2_addr;
  logic [`DATA_WIDTH-1:0]     rs1_data;
  logic [`DATA_WIDTH-1:0]     rs2_data;
  logic                       alu_start;
  logic                       mul_start;
  opcode_t                    op;
  logic [`REGISTER_WIDTH-1:0] rd;
  logic [`DATA_WIDTH-1:0]     a;
  logic [`DATA_WIDTH-1:0]     b;
  imm_t                       imm;
  logic [`ADDR_WIDTH-1:0]     pc;
  instruction_t               instr;
  logic                       wb_is_next_cycle;
  logic                       mul_done;
  logic [`REGISTER_WIDTH-1:0] mul_done_reg;

  exec_wb_if alu_wb ();
  exec_wb_if mul_wb ();

  issue_ctrl u_issue (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .instr_valid_i      (instr_valid_i),
    .instr_i            (instr_i),
    .pc_i               (pc_i),
    .rs1_data_i         (rs1_data),
    .rs2_data_i         (rs2_data),
    .wb_is_next_cycle_i (wb_is_next_cycle),
    .mul_done_i         (mul_done),
    .mul_done_reg_i     (mul_done_reg),
    .instr_stall_o      (instr_stall_o),
    .rs1_addr_o         (rs1_addr),
    .rs2_addr_o         (rs2_addr),
    .alu_start_o        (alu_start),
    .mul_start_o        (mul_start),
    .op_o               (op),
    .rd_o               (rd),
    .a_o                (a),
    .b_o                (b),
    .imm_o              (imm),
    .pc_o               (pc),
    .instr_o            (instr)
  );

  alu_stage u_alu (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .start_i       (alu_start),
    .op_i          (op),
    .rd_i          (rd),
    .a_i           (a),
    .b_i           (b),
    .imm_i         (imm),
    .debug_pc_i    (pc),
    .debug_instr_i (instr),
    .wb            (alu_wb)
  );

  ex_stages u_mul (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .valid_i            (mul_start),
    .wr_reg_i           (rd),
    .a_i                (a),
    .b_i                (b),
    .debug_pc_i         (pc),
    .debug_instr_i      (instr),
    .wb_is_next_cycle_o (wb_is_next_cycle),
    .wb                 (mul_wb)
  );

  regfile_wb u_regfile (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .rs1_addr_i     (rs1_addr),
    .rs2_addr_i     (rs2_addr),
    .dbg_raddr_i    (dbg_raddr_i),
    .alu_wb         (alu_wb),
    .mul_wb         (mul_wb),
    .rs1_data_o     (rs1_data),
    .rs2_data_o     (rs2_data),
    .dbg_rdata_o    (dbg_rdata_o),
    .retire_valid_o (retire_valid_o),
    .retire_reg_o   (retire_reg_o),
    .retire_data_o  (retire_data_o),
    .retire_pc_o    (retire_pc_o),
    .mul_done_o     (mul_done),
    .mul_done_reg_o (mul_done_reg)
  );

endmodule : exec_top

/* tb_exec_top.sv */
`timescale 1ns/1ps
`include "exec_config.svh"

module tb_exec_top;
  import exec_pkg::*;

  localparam int STALL_LIMIT = 20;
  localparam int DRAIN_LIMIT = 50;

  // One expected retire, keyed by the cycle it must show up in
  typedef struct packed {
    logic [31:0]                cycle;
    logic [`REGISTER_WIDTH-1:0] rd;
    logic [`DATA_WIDTH-1:0]     data;
    logic [`ADDR_WIDTH-1:0]     pc;
  } retire_t;

  logic                       clk;
  logic                       rst_n;
  logic                       instr_valid;
  instruction_t               instr;
  logic [`ADDR_WIDTH-1:0]     pc;
  logic [`REGISTER_WIDTH-1:0] dbg_raddr;
  logic                       instr_stall;
  logic                       retire_valid;
  logic [`REGISTER_WIDTH-1:0] retire_reg;
  logic [`DATA_WIDTH-1:0]     retire_data;
  logic [`ADDR_WIDTH-1:0]     retire_pc;
  logic [`DATA_WIDTH-1:0]     dbg_rdata;

  logic [`DATA_WIDTH-1:0] model_regs [`NUM_REGS];
  retire_t                exp_q [$];
  logic [31:0]            cycle_cnt = '0;
  logic [`ADDR_WIDTH-1:0] next_pc;
  integer                 seed;
  int                     errors = 0;
  int                     checks = 0;

  exec_top u_dut (
    .clk_i          (clk),
    .rst_i          (rst_n),
    .instr_valid_i  (instr_valid),
    .instr_i        (instr),
    .pc_i           (pc),
    .dbg_raddr_i    (dbg_raddr),
    .instr_stall_o  (instr_stall),
    .retire_valid_o (retire_valid),
    .retire_reg_o   (retire_reg),
    .retire_data_o  (retire_data),
    .retire_pc_o    (retire_pc),
    .dbg_rdata_o    (dbg_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  always @(negedge clk) begin
    if (rst_n) begin
      match_retire();
    end
  end

  task automatic check_value(input string what, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR at %0t ns: %s mismatch, got %h, expected %h", $time, what, actual,
               expected);
    end
  endtask

  // Architectural result of one instruction, products keep the low DATA_WIDTH bits
  function automatic logic [`DATA_WIDTH-1:0] model_result(input opcode_t op,
      input logic [`DATA_WIDTH-1:0] a, input logic [`DATA_WIDTH-1:0] b, input logic [15:0] imm);
    logic [2*`DATA_WIDTH-1:0] product;
    product = {{`DATA_WIDTH{1'b0}}, a} * {{`DATA_WIDTH{1'b0}}, b};
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_LI:   return {{(`DATA_WIDTH-16){1'b0}}, imm};
      OP_MUL:  return product[`DATA_WIDTH-1:0];
      default: return '0;
    endcase
  endfunction

  task automatic expect_retire(input retire_t entry);
    for (int i = 0; i < exp_q.size(); i++) begin
      if (exp_q[i].cycle == entry.cycle) begin
        errors++;
        $display("Two retires fall into cycle %0d, for r%0d and r%0d", entry.cycle,
                 exp_q[i].rd, entry.rd);
      end
    end
    exp_q.push_back(entry);
  endtask

  task automatic match_retire();
    int idx;
    idx = -1;
    for (int i = 0; i < exp_q.size(); i++) begin
      if (exp_q[i].cycle == cycle_cnt) idx = i;
    end
    if (idx < 0) begin
      if (retire_valid) begin
        errors++;
        $display("Unexpected retire of r%0d at %0t ns", retire_reg, $time);
      end
    end else begin
      check_value("retire valid", 32'(retire_valid), 32'd1);
      if (retire_valid) begin
        check_value("retire reg", 32'(retire_reg), 32'(exp_q[idx].rd));
        check_value("retire data", retire_data, exp_q[idx].data);
        check_value("retire pc", retire_pc, exp_q[idx].pc);
      end
      exp_q.delete(idx);
    end
  endtask

  // Called 10 ns after a rising edge, returns at the same point after acceptance
  task automatic issue_instr(input opcode_t op, input int rd, input int rs1, input int rs2,
                             input int imm, output int stalls);
    logic [`DATA_WIDTH-1:0] result;
    retire_t                entry;
    instr.op    = op;
    instr.rd    = `REGISTER_WIDTH'(rd);
    instr.rs1   = `REGISTER_WIDTH'(rs1);
    instr.rs2   = `REGISTER_WIDTH'(rs2);
    instr.imm   = 16'(imm);
    pc          = next_pc;
    instr_valid = 1'b1;
    stalls      = 0;
    @(negedge clk);
    while (instr_stall && stalls < STALL_LIMIT) begin
      stalls++;
      @(negedge clk);
    end
    if (instr_stall) begin
      $display("Timeout: instruction at pc %h stayed stalled for %0d cycles", pc, stalls);
      $display("Done: errors found");
      $finish;
    end else begin
      // Accepted at the coming edge, the model advances in program order
      result      = model_result(op, model_regs[instr.rs1], model_regs[instr.rs2], instr.imm);
      entry.cycle = cycle_cnt + ((op == OP_MUL) ? 32'd5 : 32'd1);
      entry.rd    = instr.rd;
      entry.data  = result;
      entry.pc    = pc;
      expect_retire(entry);
      model_regs[instr.rd] = result;
      next_pc = next_pc + 32'd4;
      @(posedge clk);
      #10;
      instr_valid = 1'b0;
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      #10;
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("Timeout: %0d expected retires never arrived", exp_q.size());
      $display("Done: errors found");
      $finish;
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #10;
    end
  endtask

  task automatic check_regs(input string tag);
    for (int i = 0; i < `NUM_REGS; i++) begin
      dbg_raddr = `REGISTER_WIDTH'(i);
      @(negedge clk);
      check_value($sformatf("%s r%0d", tag, i), dbg_rdata, model_regs[i]);
      @(posedge clk);
      #10;
    end
  endtask

  task automatic test_reset_state();
    check_regs("reset");
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      check_value("idle retire valid", 32'(retire_valid), 32'd0);
      check_value("idle stall", 32'(instr_stall), 32'd0);
      @(posedge clk);
      #10;
    end
  endtask

  task automatic test_alu_ops();
    int st;
    issue_instr(OP_LI, 1, 0, 0, $random(seed) & 32'hffff, st);
    issue_instr(OP_LI, 2, 0, 0, $random(seed) & 32'hffff, st);
    issue_instr(OP_ADD, 3, 1, 2, 0, st);
    issue_instr(OP_SUB, 4, 1, 2, 0, st);
    issue_instr(OP_AND, 5, 1, 2, 0, st);
    issue_instr(OP_OR, 6, 1, 2, 0, st);
    issue_instr(OP_XOR, 7, 1, 2, 0, st);
    wait_drain();
    check_regs("alu");
  endtask

  task automatic test_mul_latency();
    int st;
    issue_instr(OP_MUL, 10, 3, 4, 0, st);
    wait_drain();
    issue_instr(OP_MUL, 11, 1, 2, 0, st);
    issue_instr(OP_MUL, 12, 5, 6, 0, st);
    check_value("mul burst stalls", 32'(st), 32'd0);
    issue_instr(OP_MUL, 13, 6, 7, 0, st);
    check_value("mul burst stalls", 32'(st), 32'd0);
    issue_instr(OP_MUL, 14, 4, 7, 0, st);
    check_value("mul burst stalls", 32'(st), 32'd0);
    wait_drain();
    issue_instr(OP_MUL, 15, 10, 11, 0, st); // Wide operands, product gets truncated
    wait_drain();
    check_regs("mul");
  endtask

  task automatic test_bypass_chain();
    int st;
    issue_instr(OP_ADD, 20, 1, 2, 0, st);
    issue_instr(OP_ADD, 21, 20, 1, 0, st);
    check_value("chain stalls", 32'(st), 32'd0);
    issue_instr(OP_XOR, 22, 21, 20, 0, st);
    check_value("chain stalls", 32'(st), 32'd0);
    issue_instr(OP_SUB, 20, 22, 21, 0, st);
    check_value("chain stalls", 32'(st), 32'd0);
    wait_drain();
    check_regs("bypass");
  endtask

  task automatic test_hazards();
    int st;
    // The scoreboard bit clears at the writeback edge, five cycles after issue
    issue_instr(OP_MUL, 23, 1, 2, 0, st);
    issue_instr(OP_ADD, 24, 23, 1, 0, st);
    check_value("raw hazard stalls", 32'(st), 32'd5);
    wait_drain();
    issue_instr(OP_MUL, 25, 3, 5, 0, st);
    idle_cycles(3);
    issue_instr(OP_OR, 26, 1, 2, 0, st);
    check_value("writeback slot stalls", 32'(st), 32'd1);
    wait_drain();
    check_regs("hazard");
  endtask

  task automatic test_random_mix();
    int st;
    int op_sel;
    for (int n = 0; n < 40; n++) begin
      op_sel = {$random(seed)} % 7;
      issue_instr(opcode_t'(op_sel[2:0]), {$random(seed)} % `NUM_REGS,
                  {$random(seed)} % `NUM_REGS, {$random(seed)} % `NUM_REGS,
                  $random(seed) & 32'hffff, st);
    end
    wait_drain();
    check_regs("random");
  endtask

  initial begin
    seed        = 32'ha6998798;
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    pc          = '0;
    dbg_raddr   = '0;
    next_pc     = 32'h100;
    for (int i = 0; i < `NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    repeat (5) @(posedge clk);
    #10;
    rst_n = 1'b1;
    test_reset_state();
    test_alu_ops();
    test_mul_latency();
    test_bypass_chain();
    test_hazards();
    test_random_mix();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule : tb_exec_top

/* compile.f */
+incdir+.
exec_pkg.sv
exec_wb_if.sv
issue_ctrl.sv
alu_stage.sv
ex_stages.sv
regfile_wb.sv
exec_top.sv
tb_exec_top.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it into sim.log and checks the result

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f compile.f --top-module tb_exec_top -Mdir obj_dir -o Vtb_exec_top
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_exec_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
  echo "Simulation failed, see $LOG"
  exit 1
fi

echo "Simulation passed"
exit 0
